//--- addr_xlate.sv
/*
 * Per-port address translation. Strips the unmapped segment bases,
 * forms the mapped physical address and raises the TLB exception flags.
 */
`include "mmu_config.svh"

module addr_xlate (
    input  mmu_pkg::vaddr_t       vaddr,
    input  mmu_pkg::mem_access_t  access,
    input  logic                  found,
    input  logic                  v,
    input  logic                  d,
    input  logic [19:0]           pfn,
    output logic [31:0]           paddr,
    output logic [mmu_pkg::EXC_W-1:0] excp
);
    import mmu_pkg::*;

    logic mapped;

    always_comb begin
        mapped = 1'b0;
        case (vaddr.segment.seg)
            SEG_KSEG0: paddr = vaddr - `KSEG0_BASE;
            SEG_KSEG1: paddr = vaddr - `KSEG1_BASE;
            default: begin
                mapped = 1'b1;
                paddr  = {pfn, vaddr.mapped.offset};
            end
        endcase
    end

    // refill over invalid over modified
    always_comb begin
        excp = '0;
        if (mapped && access != ACC_NONE) begin
            if (!found)
                excp[EXC_REFILL] = 1'b1;
            else if (!v)
                excp[EXC_INVALID] = 1'b1;
            else if (access == ACC_STORE && !d)
                excp[EXC_MODIFIED] = 1'b1;
        end
    end

endmodule

//--- cp0_pkg.sv
/*
 * CP0 register map seen over APB: offsets, TLB command codes and the
 * bit positions of the Index, EntryHi and EntryLo fields.
 */
`include "mmu_config.svh"

package cp0_pkg;

    localparam logic [`APB_ADDR_W-1:0] REG_INDEX    = 5'h00;
    localparam logic [`APB_ADDR_W-1:0] REG_ENTRYHI  = 5'h04;
    localparam logic [`APB_ADDR_W-1:0] REG_ENTRYLO0 = 5'h08;
    localparam logic [`APB_ADDR_W-1:0] REG_ENTRYLO1 = 5'h0C;
    localparam logic [`APB_ADDR_W-1:0] REG_COMMAND  = 5'h10;

    localparam logic [31:0] CMD_TLBR  = 32'd1;
    localparam logic [31:0] CMD_TLBWI = 32'd2;
    localparam logic [31:0] CMD_TLBP  = 32'd3;

    // field LSBs, widths are fixed by the TLB ports
    localparam int EHI_VPN2_LSB = 13;
    localparam int EHI_ASID_LSB = 0;
    localparam int ELO_PFN_LSB  = 6;
    localparam int ELO_C_LSB    = 3;
    localparam int ELO_D        = 2;
    localparam int ELO_V        = 1;
    localparam int ELO_G        = 0;
    localparam int IDX_P        = 31;  // probe failure
    localparam int IDX_LSB      = 0;

endpackage

//--- cp0_tlb_regs.sv
/*
 * APB slave for the TLB side of CP0. Holds Index, EntryHi, EntryLo0/1,
 * turns command writes into TLBR, TLBWI and TLBP and captures their results.
 */
`include "mmu_config.svh"

module cp0_tlb_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`APB_ADDR_W-1:0]  paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic [18:0]             entryhi_vpn2,
    output logic [7:0]              entryhi_asid,
    output logic                    probe_active,
    output logic                    tlb_we,
    output logic [`TLB_INDEX_W-1:0] w_index,
    output logic [18:0]             w_vpn2,
    output logic [7:0]              w_asid,
    output logic                    w_g,
    output logic [19:0]             w_pfn0,
    output logic [2:0]              w_c0,
    output logic                    w_d0,
    output logic                    w_v0,
    output logic [19:0]             w_pfn1,
    output logic [2:0]              w_c1,
    output logic                    w_d1,
    output logic                    w_v1,
    output logic [`TLB_INDEX_W-1:0] r_index,
    input  logic [18:0]             r_vpn2,
    input  logic [7:0]              r_asid,
    input  logic                    r_g,
    input  logic [19:0]             r_pfn0,
    input  logic [2:0]              r_c0,
    input  logic                    r_d0,
    input  logic                    r_v0,
    input  logic [19:0]             r_pfn1,
    input  logic [2:0]              r_c1,
    input  logic                    r_d1,
    input  logic                    r_v1,
    input  logic                    s1_found,
    input  logic [`TLB_INDEX_W-1:0] s1_index
);
    import cp0_pkg::*;

    logic                    index_p;
    logic [`TLB_INDEX_W-1:0] index_val;
    logic [19:0]             pfn0, pfn1;
    logic [2:0]              c0, c1;
    logic                    d0, d1, v0, v1, g0, g1;

    logic access, addr_ok, is_cmd, cmd_ok, wr, cmd_wr;

    assign access  = psel && penable;
    assign addr_ok = paddr inside {REG_INDEX, REG_ENTRYHI, REG_ENTRYLO0, REG_ENTRYLO1,
                                   REG_COMMAND};
    assign is_cmd  = paddr == REG_COMMAND;
    assign cmd_ok  = pwdata inside {CMD_TLBR, CMD_TLBWI, CMD_TLBP};

    assign pready  = 1'b1;  // no wait states
    assign pslverr = access && (!addr_ok || (pwrite && is_cmd && !cmd_ok));
    assign wr      = access && pwrite && !pslverr;
    assign cmd_wr  = wr && is_cmd;

    assign tlb_we       = cmd_wr && pwdata == CMD_TLBWI;
    assign probe_active = cmd_wr && pwdata == CMD_TLBP;

    assign entryhi_vpn2 = w_vpn2;
    assign entryhi_asid = w_asid;
    assign w_index      = index_val;
    assign r_index      = index_val;
    assign w_g          = g0 & g1;  // entry is global only if both halves say so
    assign {w_pfn0, w_c0, w_d0, w_v0} = {pfn0, c0, d0, v0};
    assign {w_pfn1, w_c1, w_d1, w_v1} = {pfn1, c1, d1, v1};

    always_ff @(posedge clk) begin
        if (rst) begin
            index_p   <= 1'b0;
            index_val <= '0;
            w_vpn2    <= '0;
            w_asid    <= '0;
            {pfn0, c0, d0, v0, g0} <= '0;
            {pfn1, c1, d1, v1, g1} <= '0;
        end else if (wr) begin
            case (paddr)
                REG_INDEX:    index_val <= pwdata[IDX_LSB +: `TLB_INDEX_W];  // P is read only
                REG_ENTRYHI: begin
                    w_vpn2 <= pwdata[EHI_VPN2_LSB +: 19];
                    w_asid <= pwdata[EHI_ASID_LSB +: 8];
                end
                REG_ENTRYLO0: begin
                    pfn0 <= pwdata[ELO_PFN_LSB +: 20];
                    c0   <= pwdata[ELO_C_LSB +: 3];
                    {d0, v0, g0} <= {pwdata[ELO_D], pwdata[ELO_V], pwdata[ELO_G]};
                end
                REG_ENTRYLO1: begin
                    pfn1 <= pwdata[ELO_PFN_LSB +: 20];
                    c1   <= pwdata[ELO_C_LSB +: 3];
                    {d1, v1, g1} <= {pwdata[ELO_D], pwdata[ELO_V], pwdata[ELO_G]};
                end
                REG_COMMAND: begin
                    if (pwdata == CMD_TLBR) begin
                        w_vpn2 <= r_vpn2;
                        w_asid <= r_asid;
                        {pfn0, c0, d0, v0, g0} <= {r_pfn0, r_c0, r_d0, r_v0, r_g};
                        {pfn1, c1, d1, v1, g1} <= {r_pfn1, r_c1, r_d1, r_v1, r_g};
                    end else if (pwdata == CMD_TLBP) begin
                        index_p <= !s1_found;
                        if (s1_found)
                            index_val <= s1_index;
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_INDEX: begin
                prdata[IDX_P]                      = index_p;
                prdata[IDX_LSB +: `TLB_INDEX_W]    = index_val;
            end
            REG_ENTRYHI: begin
                prdata[EHI_VPN2_LSB +: 19] = w_vpn2;
                prdata[EHI_ASID_LSB +: 8]  = w_asid;
            end
            REG_ENTRYLO0: begin
                prdata[ELO_PFN_LSB +: 20] = pfn0;
                prdata[ELO_C_LSB +: 3]    = c0;
                {prdata[ELO_D], prdata[ELO_V], prdata[ELO_G]} = {d0, v0, g0};
            end
            REG_ENTRYLO1: begin
                prdata[ELO_PFN_LSB +: 20] = pfn1;
                prdata[ELO_C_LSB +: 3]    = c1;
                {prdata[ELO_D], prdata[ELO_V], prdata[ELO_G]} = {d1, v1, g1};
            end
            default: prdata = '0;  // command reads back as zero
        endcase
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

    // a TLB write only lands in an access phase that followed a setup phase
    a_we_access: assert property (@(posedge clk) disable iff (rst)
        tlb_we |-> $past(psel && !penable));

endmodule

//--- mmu_config.svh
/*
 * Sizing of the TLB and the APB register window, plus the bases of the
 * two unmapped segments. Included by every file that needs them.
 */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

`define TLB_ENTRIES 16
`define TLB_INDEX_W 4

`define APB_ADDR_W 5

// subtracted from unmapped addresses
`define KSEG0_BASE 32'h8000_0000
`define KSEG1_BASE 32'hA000_0000

`endif

//--- mmu_pkg.sv
/*
 * Types shared by the translation path: the virtual address views,
 * the data access type and the layout of the exception flag vector.
 */
package mmu_pkg;

    // one address word, read as a page split or as a segment split
    typedef union packed {
        struct packed {
            logic [18:0] vpn2;
            logic        odd;     // selects even/odd page of the pair
            logic [11:0] offset;
        } mapped;
        struct packed {
            logic [2:0]  seg;
            logic [28:0] rest;
        } segment;
    } vaddr_t;

    localparam logic [2:0] SEG_KSEG0 = 3'd4;  // cached, unmapped
    localparam logic [2:0] SEG_KSEG1 = 3'd5;  // uncached, unmapped

    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } mem_access_t;

    // exception vector bits
    localparam int EXC_REFILL   = 0;
    localparam int EXC_INVALID  = 1;
    localparam int EXC_MODIFIED = 2;
    localparam int EXC_W        = 3;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build the MMU testbench with Verilator, run it and look for the pass message.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tlb_mmu.f --top-module tb_tlb_mmu; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_tlb_mmu)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

//--- tb_tlb_mmu.sv
/*
 * Table-driven testbench for the MMU. Rows of APB register accesses and
 * fetch/data translations are built at time zero, then applied in order.
 */
`include "mmu_config.svh"

module tb_tlb_mmu;
    timeunit 1ns;
    timeprecision 100ps;

    import mmu_pkg::*;
    import cp0_pkg::*;

    typedef enum logic [1:0] {K_WRITE, K_READ, K_IFETCH, K_DATA} row_kind_t;

    typedef struct {
        string       name;
        row_kind_t   kind;
        logic [31:0] addr;   // APB offset or virtual address
        logic [31:0] data;   // write data or access type
        logic [31:0] exp;
        logic [31:0] mask;   // bits of exp that count
        logic [2:0]  flags;
        logic        err;
    } row_t;

    localparam logic [2:0]  F_NONE = 3'b000;
    localparam logic [2:0]  F_REF  = 3'(1 << EXC_REFILL);
    localparam logic [2:0]  F_INV  = 3'(1 << EXC_INVALID);
    localparam logic [2:0]  F_MOD  = 3'(1 << EXC_MODIFIED);
    localparam logic [31:0] ALL    = 32'hFFFF_FFFF;

    // vpn2 values, all in mapped segments
    localparam logic [18:0] VPN_A = 19'h1_2345;
    localparam logic [18:0] VPN_B = 19'h0_0ABC;
    localparam logic [18:0] VPN_C = 19'h3_1000;
    localparam logic [18:0] VPN_G = 19'h6_0F0F;
    localparam logic [18:0] VPN_H = 19'h7_7777;

    logic                   clk = 1'b0;
    logic                   rst;
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   psel, penable, pwrite;
    logic [31:0]            pwdata, prdata;
    logic                   pready, pslverr;
    logic [31:0]            i_vaddr, i_paddr, d_vaddr, d_paddr;
    logic                   i_refill, i_invalid;
    logic [1:0]             d_type;
    logic                   d_refill, d_invalid, d_modified;

    row_t rows[$];
    int   errors      = 0;
    int   cycles      = 0;
    int   cycle_limit = 0;

    tlb_mmu uut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("%0d errors in %0d rows", errors, rows.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] mapped_va(logic [18:0] vpn2, logic odd, logic [11:0] off);
        vaddr_t v;
        v.mapped.vpn2   = vpn2;
        v.mapped.odd    = odd;
        v.mapped.offset = off;
        return v;
    endfunction

    function automatic logic [31:0] entry_hi(logic [18:0] vpn2, logic [7:0] asid);
        logic [31:0] w;
        w = '0;
        w[EHI_VPN2_LSB +: 19] = vpn2;
        w[EHI_ASID_LSB +: 8]  = asid;
        return w;
    endfunction

    function automatic logic [31:0] entry_lo(logic [19:0] pfn, logic [2:0] c,
                                             logic d, logic v, logic g);
        logic [31:0] w;
        w = '0;
        w[ELO_PFN_LSB +: 20] = pfn;
        w[ELO_C_LSB +: 3]    = c;
        w[ELO_D]             = d;
        w[ELO_V]             = v;
        w[ELO_G]             = g;
        return w;
    endfunction

    task automatic add_row(string name, row_kind_t kind, logic [31:0] addr, logic [31:0] data,
                           logic [31:0] exp, logic [31:0] mask, logic [2:0] flags, logic err);
        rows.push_back('{name, kind, addr, data, exp, mask, flags, err});
    endtask

    task automatic wr_reg(string name, logic [`APB_ADDR_W-1:0] a, logic [31:0] d);
        add_row(name, K_WRITE, 32'(a), d, '0, '0, F_NONE, 1'b0);
    endtask

    task automatic rd_reg(string name, logic [`APB_ADDR_W-1:0] a, logic [31:0] exp);
        add_row(name, K_READ, 32'(a), '0, exp, ALL, F_NONE, 1'b0);
    endtask

    task automatic load_entry(logic [3:0] idx, logic [18:0] vpn2, logic [7:0] asid,
                              logic [31:0] lo0, logic [31:0] lo1);
        wr_reg("index", REG_INDEX, 32'(idx));
        wr_reg("entryhi", REG_ENTRYHI, entry_hi(vpn2, asid));
        wr_reg("entrylo0", REG_ENTRYLO0, lo0);
        wr_reg("entrylo1", REG_ENTRYLO1, lo1);
        wr_reg("tlbwi", REG_COMMAND, CMD_TLBWI);
    endtask

    task automatic build_table();
        logic [31:0] rnd, a;
        logic [11:0] off;
        for (int n = 0; n < 3; n++) begin  // unmapped segments, TLB still empty
            rnd = $urandom;
            a   = `KSEG0_BASE + (rnd & 32'h1FFF_FFFF);
            add_row("kseg0 fetch", K_IFETCH, a, '0, a - `KSEG0_BASE, ALL, F_NONE, 1'b0);
            add_row("kseg0 store", K_DATA, a, 32'(ACC_STORE), a - `KSEG0_BASE, ALL, F_NONE, 1'b0);
            rnd = $urandom;
            a   = `KSEG1_BASE + (rnd & 32'h1FFF_FFFF);
            add_row("kseg1 fetch", K_IFETCH, a, '0, a - `KSEG1_BASE, ALL, F_NONE, 1'b0);
            add_row("kseg1 load", K_DATA, a, 32'(ACC_LOAD), a - `KSEG1_BASE, ALL, F_NONE, 1'b0);
        end
        rnd = $urandom;
        off = rnd[11:0];
        add_row("empty fetch", K_IFETCH, mapped_va(VPN_A, 1'b0, off), '0, '0, '0, F_REF, 1'b0);
        add_row("empty load", K_DATA, mapped_va(VPN_A, 1'b1, off), 32'(ACC_LOAD), '0, '0, F_REF,
                1'b0);

        load_entry(4'd3, VPN_A, 8'h11, entry_lo(20'h0_1234, 3'd3, 1'b1, 1'b1, 1'b0),
                   entry_lo(20'h0_5678, 3'd2, 1'b0, 1'b1, 1'b0));
        load_entry(4'd2, VPN_C, 8'h11, entry_lo(20'h0_9999, 3'd2, 1'b0, 1'b0, 1'b0),
                   entry_lo(20'h0_AAAA, 3'd2, 1'b1, 1'b1, 1'b0));
        load_entry(4'd5, VPN_G, 8'h22, entry_lo(20'hA_BCDE, 3'd5, 1'b1, 1'b1, 1'b1),
                   entry_lo(20'h1_1111, 3'd0, 1'b1, 1'b1, 1'b1));
        load_entry(4'd6, VPN_H, 8'h44, entry_lo(20'h2_2222, 3'd1, 1'b1, 1'b1, 1'b1),
                   entry_lo(20'h3_3333, 3'd7, 1'b1, 1'b1, 1'b0));
        wr_reg("asid 11", REG_ENTRYHI, entry_hi(VPN_A, 8'h11));

        rnd = $urandom;
        off = rnd[11:0];
        add_row("fetch even", K_IFETCH, mapped_va(VPN_A, 1'b0, off), '0, {20'h0_1234, off}, ALL,
                F_NONE, 1'b0);
        add_row("fetch odd", K_IFETCH, mapped_va(VPN_A, 1'b1, off), '0, {20'h0_5678, off}, ALL,
                F_NONE, 1'b0);
        add_row("load odd", K_DATA, mapped_va(VPN_A, 1'b1, off), 32'(ACC_LOAD),
                {20'h0_5678, off}, ALL, F_NONE, 1'b0);
        add_row("store odd clean", K_DATA, mapped_va(VPN_A, 1'b1, off), 32'(ACC_STORE), '0, '0,
                F_MOD, 1'b0);
        add_row("store even", K_DATA, mapped_va(VPN_A, 1'b0, off), 32'(ACC_STORE),
                {20'h0_1234, off}, ALL, F_NONE, 1'b0);
        add_row("none miss", K_DATA, mapped_va(VPN_B, 1'b0, off), 32'(ACC_NONE), '0, '0, F_NONE,
                1'b0);
        add_row("fetch miss", K_IFETCH, mapped_va(VPN_B, 1'b1, off), '0, '0, '0, F_REF, 1'b0);
        add_row("load miss", K_DATA, mapped_va(VPN_B, 1'b0, off), 32'(ACC_LOAD), '0, '0, F_REF,
                1'b0);
        add_row("fetch invalid", K_IFETCH, mapped_va(VPN_C, 1'b0, off), '0, '0, '0, F_INV, 1'b0);
        add_row("store invalid", K_DATA, mapped_va(VPN_C, 1'b0, off), 32'(ACC_STORE), '0, '0,
                F_INV, 1'b0);
        add_row("store c odd", K_DATA, mapped_va(VPN_C, 1'b1, off), 32'(ACC_STORE),
                {20'h0_AAAA, off}, ALL, F_NONE, 1'b0);
        add_row("global fetch", K_IFETCH, mapped_va(VPN_G, 1'b0, off), '0, {20'hA_BCDE, off},
                ALL, F_NONE, 1'b0);
        add_row("global load", K_DATA, mapped_va(VPN_G, 1'b1, off), 32'(ACC_LOAD),
                {20'h1_1111, off}, ALL, F_NONE, 1'b0);
        add_row("half global", K_IFETCH, mapped_va(VPN_H, 1'b0, off), '0, '0, '0, F_REF, 1'b0);
        wr_reg("asid 44", REG_ENTRYHI, entry_hi(VPN_H, 8'h44));
        add_row("own asid fetch", K_IFETCH, mapped_va(VPN_H, 1'b1, off), '0, {20'h3_3333, off},
                ALL, F_NONE, 1'b0);
        wr_reg("asid 22", REG_ENTRYHI, entry_hi(VPN_A, 8'h22));
        add_row("asid mismatch", K_DATA, mapped_va(VPN_A, 1'b0, off), 32'(ACC_LOAD), '0, '0,
                F_REF, 1'b0);

        wr_reg("probe a hi", REG_ENTRYHI, entry_hi(VPN_A, 8'h11));
        wr_reg("tlbp a", REG_COMMAND, CMD_TLBP);
        rd_reg("probe a index", REG_INDEX, 32'd3);
        wr_reg("probe b hi", REG_ENTRYHI, entry_hi(VPN_B, 8'h11));
        wr_reg("tlbp b", REG_COMMAND, CMD_TLBP);
        add_row("probe b miss", K_READ, 32'(REG_INDEX), '0, 32'h8000_0000, 32'h8000_0000,
                F_NONE, 1'b0);
        wr_reg("probe g hi", REG_ENTRYHI, entry_hi(VPN_G, 8'h99));
        wr_reg("tlbp g", REG_COMMAND, CMD_TLBP);
        rd_reg("probe g index", REG_INDEX, 32'd5);

        wr_reg("index 5", REG_INDEX, 32'd5);
        wr_reg("tlbr 5", REG_COMMAND, CMD_TLBR);
        rd_reg("tlbr 5 hi", REG_ENTRYHI, entry_hi(VPN_G, 8'h22));
        rd_reg("tlbr 5 lo0", REG_ENTRYLO0, entry_lo(20'hA_BCDE, 3'd5, 1'b1, 1'b1, 1'b1));
        rd_reg("tlbr 5 lo1", REG_ENTRYLO1, entry_lo(20'h1_1111, 3'd0, 1'b1, 1'b1, 1'b1));
        wr_reg("index 6", REG_INDEX, 32'd6);
        wr_reg("tlbr 6", REG_COMMAND, CMD_TLBR);
        rd_reg("tlbr 6 hi", REG_ENTRYHI, entry_hi(VPN_H, 8'h44));
        rd_reg("tlbr 6 lo0", REG_ENTRYLO0, entry_lo(20'h2_2222, 3'd1, 1'b1, 1'b1, 1'b0));
        rd_reg("tlbr 6 lo1", REG_ENTRYLO1, entry_lo(20'h3_3333, 3'd7, 1'b1, 1'b1, 1'b0));

        add_row("bad offset wr", K_WRITE, 32'h14, ALL, '0, '0, F_NONE, 1'b1);
        add_row("misaligned wr", K_WRITE, 32'h05, ALL, '0, '0, F_NONE, 1'b1);
        add_row("bad offset rd", K_READ, 32'h18, '0, '0, '0, F_NONE, 1'b1);
        add_row("bad command", K_WRITE, 32'(REG_COMMAND), 32'd7, '0, '0, F_NONE, 1'b1);
        add_row("zero command", K_WRITE, 32'(REG_COMMAND), 32'd0, '0, '0, F_NONE, 1'b1);
        rd_reg("index kept", REG_INDEX, 32'd6);
        rd_reg("entryhi kept", REG_ENTRYHI, entry_hi(VPN_H, 8'h44));
        rd_reg("entrylo1 kept", REG_ENTRYLO1, entry_lo(20'h3_3333, 3'd7, 1'b1, 1'b1, 1'b0));
    endtask

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic apb_transfer(logic wr, logic [`APB_ADDR_W-1:0] a, logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err,
                                output logic rdy);
        @(posedge clk);
        #0.5;
        paddr   = a;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #0.5;
        penable = 1'b1;
        @(negedge clk);  // access phase
        rdata = prdata;
        err   = pslverr;
        rdy   = pready;
        @(posedge clk);
        #0.5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apply_row(row_t r);
        logic [31:0] rdata, act_paddr;
        logic        err, rdy;
        logic [2:0]  act_flags;
        if (r.kind == K_WRITE || r.kind == K_READ) begin
            apb_transfer(r.kind == K_WRITE, r.addr[`APB_ADDR_W-1:0], r.data, rdata, err, rdy);
            check({r.name, " pready"}, 32'd1, 32'(rdy));
            if (err !== r.err) begin
                $display("%s: %s", r.name,
                         err ? "slave raised an unexpected APB error" : "slave missed an APB error");
                errors++;
            end
            if (r.kind == K_READ)
                check(r.name, r.exp & r.mask, rdata & r.mask);
        end else begin
            @(posedge clk);
            #0.5;
            if (r.kind == K_IFETCH) begin
                i_vaddr = r.addr;
            end else begin
                d_vaddr = r.addr;
                d_type  = r.data[1:0];
            end
            @(negedge clk);
            act_flags = '0;
            if (r.kind == K_IFETCH) begin
                act_paddr              = i_paddr;
                act_flags[EXC_REFILL]  = i_refill;
                act_flags[EXC_INVALID] = i_invalid;
            end else begin
                act_paddr               = d_paddr;
                act_flags[EXC_REFILL]   = d_refill;
                act_flags[EXC_INVALID]  = d_invalid;
                act_flags[EXC_MODIFIED] = d_modified;
            end
            check(r.name, r.exp & r.mask, act_paddr & r.mask);
            check({r.name, " flags"}, 32'(r.flags), 32'(act_flags));
        end
    endtask

    initial begin
        void'($urandom(61));
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        i_vaddr = '0;
        d_vaddr = '0;
        d_type  = 2'(ACC_NONE);
        build_table();
        cycle_limit = rows.size() * 4 + 100;
        repeat (4) @(posedge clk);
        #0.5;
        rst = 1'b0;
        foreach (rows[n])
            apply_row(rows[n]);
        $display("%0d errors in %0d rows", errors, rows.size());
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- tlb.sv
/*
 * Fully associative dual-page TLB. Two combinational search ports,
 * one write port for TLBWI and one read port for TLBR.
 */
`include "mmu_config.svh"

module tlb (
    input  logic                    clk,
    input  logic                    rst,
    // search port 0
    input  logic [18:0]             s0_vpn2,
    input  logic                    s0_odd_page,
    input  logic [7:0]              s0_asid,
    output logic                    s0_found,
    output logic [`TLB_INDEX_W-1:0] s0_index,
    output logic [19:0]             s0_pfn,
    output logic [2:0]              s0_c,
    output logic                    s0_d,
    output logic                    s0_v,
    // search port 1
    input  logic [18:0]             s1_vpn2,
    input  logic                    s1_odd_page,
    input  logic [7:0]              s1_asid,
    output logic                    s1_found,
    output logic [`TLB_INDEX_W-1:0] s1_index,
    output logic [19:0]             s1_pfn,
    output logic [2:0]              s1_c,
    output logic                    s1_d,
    output logic                    s1_v,
    // write port
    input  logic                    we,
    input  logic [`TLB_INDEX_W-1:0] w_index,
    input  logic [18:0]             w_vpn2,
    input  logic [7:0]              w_asid,
    input  logic                    w_g,
    input  logic [19:0]             w_pfn0,
    input  logic [2:0]              w_c0,
    input  logic                    w_d0,
    input  logic                    w_v0,
    input  logic [19:0]             w_pfn1,
    input  logic [2:0]              w_c1,
    input  logic                    w_d1,
    input  logic                    w_v1,
    // read port
    input  logic [`TLB_INDEX_W-1:0] r_index,
    output logic [18:0]             r_vpn2,
    output logic [7:0]              r_asid,
    output logic                    r_g,
    output logic [19:0]             r_pfn0,
    output logic [2:0]              r_c0,
    output logic                    r_d0,
    output logic                    r_v0,
    output logic [19:0]             r_pfn1,
    output logic [2:0]              r_c1,
    output logic                    r_d1,
    output logic                    r_v1
);
    logic [`TLB_ENTRIES-1:0] filled;
    logic [18:0] e_vpn2 [`TLB_ENTRIES];
    logic [7:0]  e_asid [`TLB_ENTRIES];
    logic        e_g    [`TLB_ENTRIES];
    logic [24:0] e_lo0  [`TLB_ENTRIES];  // {pfn, c, d, v}
    logic [24:0] e_lo1  [`TLB_ENTRIES];

    logic [`TLB_ENTRIES-1:0] hit0, hit1;

    always_ff @(posedge clk) begin
        if (rst)
            filled <= '0;
        else if (we)
            filled[w_index] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (we) begin
            e_vpn2[w_index] <= w_vpn2;
            e_asid[w_index] <= w_asid;
            e_g[w_index]    <= w_g;
            e_lo0[w_index]  <= {w_pfn0, w_c0, w_d0, w_v0};
            e_lo1[w_index]  <= {w_pfn1, w_c1, w_d1, w_v1};
        end
    end

    // CAM compare, empty entries never hit
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            hit0[i] = filled[i] && e_vpn2[i] == s0_vpn2 && (e_g[i] || e_asid[i] == s0_asid);
            hit1[i] = filled[i] && e_vpn2[i] == s1_vpn2 && (e_g[i] || e_asid[i] == s1_asid);
        end
    end

    always_comb begin
        s0_index = '0;
        s1_index = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (hit0[i])
                s0_index = i[`TLB_INDEX_W-1:0];
            if (hit1[i])
                s1_index = i[`TLB_INDEX_W-1:0];
        end
    end

    assign s0_found = |hit0;
    assign s1_found = |hit1;
    assign {s0_pfn, s0_c, s0_d, s0_v} = s0_odd_page ? e_lo1[s0_index] : e_lo0[s0_index];
    assign {s1_pfn, s1_c, s1_d, s1_v} = s1_odd_page ? e_lo1[s1_index] : e_lo0[s1_index];

    assign r_vpn2 = e_vpn2[r_index];
    assign r_asid = e_asid[r_index];
    assign r_g    = e_g[r_index];
    assign {r_pfn0, r_c0, r_d0, r_v0} = e_lo0[r_index];
    assign {r_pfn1, r_c1, r_d1, r_v1} = e_lo1[r_index];

    // software must not load overlapping entries
    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        $onehot0(hit0) && $onehot0(hit1));

endmodule

//--- tlb_mmu.f
+incdir+.
mmu_pkg.sv
cp0_pkg.sv
cp0_tlb_regs.sv
tlb.sv
addr_xlate.sv
tlb_mmu.sv
tb_tlb_mmu.sv

//--- tlb_mmu.sv
/*
 * MMU top level. Translates a fetch and a data address each cycle and
 * exposes the TLB management registers on an APB slave port.
 */
`include "mmu_config.svh"

module tlb_mmu (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic [31:0]            i_vaddr,
    output logic [31:0]            i_paddr,
    output logic                   i_refill,
    output logic                   i_invalid,
    input  logic [31:0]            d_vaddr,
    input  logic [1:0]             d_type,
    output logic [31:0]            d_paddr,
    output logic                   d_refill,
    output logic                   d_invalid,
    output logic                   d_modified
);
    import mmu_pkg::*;

    vaddr_t i_va, d_va;
    logic [EXC_W-1:0] i_excp, d_excp;

    logic [18:0] ehi_vpn2, s1_vpn2;
    logic [7:0]  ehi_asid;
    logic        probe_active, tlb_we;

    logic                    s0_found, s0_d, s0_v, s1_found, s1_d, s1_v;
    logic [`TLB_INDEX_W-1:0] s0_index, s1_index, w_index, r_index;
    logic [19:0]             s0_pfn, s1_pfn;
    logic [2:0]              s0_c, s1_c;

    logic [18:0] w_vpn2, r_vpn2;
    logic [7:0]  w_asid, r_asid;
    logic        w_g, r_g;
    logic [19:0] w_pfn0, w_pfn1, r_pfn0, r_pfn1;
    logic [2:0]  w_c0, w_c1, r_c0, r_c1;
    logic        w_d0, w_d1, w_v0, w_v1, r_d0, r_d1, r_v0, r_v1;

    assign i_va = i_vaddr;
    assign d_va = d_vaddr;

    assign s1_vpn2 = probe_active ? ehi_vpn2 : d_va.mapped.vpn2;  // TLBP borrows port 1

    cp0_tlb_regs u_regs (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .entryhi_vpn2 (ehi_vpn2),
        .entryhi_asid (ehi_asid),
        .probe_active, .tlb_we,
        .w_index, .w_vpn2, .w_asid, .w_g,
        .w_pfn0, .w_c0, .w_d0, .w_v0, .w_pfn1, .w_c1, .w_d1, .w_v1,
        .r_index, .r_vpn2, .r_asid, .r_g,
        .r_pfn0, .r_c0, .r_d0, .r_v0, .r_pfn1, .r_c1, .r_d1, .r_v1,
        .s1_found, .s1_index
    );

    tlb u_tlb (
        .clk, .rst,
        .s0_vpn2 (i_va.mapped.vpn2), .s0_odd_page (i_va.mapped.odd), .s0_asid (ehi_asid),
        .s0_found, .s0_index, .s0_pfn, .s0_c, .s0_d, .s0_v,
        .s1_vpn2, .s1_odd_page (d_va.mapped.odd), .s1_asid (ehi_asid),
        .s1_found, .s1_index, .s1_pfn, .s1_c, .s1_d, .s1_v,
        .we (tlb_we), .w_index, .w_vpn2, .w_asid, .w_g,
        .w_pfn0, .w_c0, .w_d0, .w_v0, .w_pfn1, .w_c1, .w_d1, .w_v1,
        .r_index, .r_vpn2, .r_asid, .r_g,
        .r_pfn0, .r_c0, .r_d0, .r_v0, .r_pfn1, .r_c1, .r_d1, .r_v1
    );

    addr_xlate u_ixlate (
        .vaddr (i_va), .access (ACC_LOAD),  // fetch behaves as a load
        .found (s0_found), .v (s0_v), .d (s0_d), .pfn (s0_pfn),
        .paddr (i_paddr), .excp (i_excp)
    );

    addr_xlate u_dxlate (
        .vaddr (d_va), .access (mem_access_t'(d_type)),
        .found (s1_found), .v (s1_v), .d (s1_d), .pfn (s1_pfn),
        .paddr (d_paddr), .excp (d_excp)
    );

    assign {i_refill, i_invalid} = {i_excp[EXC_REFILL], i_excp[EXC_INVALID]};
    assign d_refill   = d_excp[EXC_REFILL];
    assign d_invalid  = d_excp[EXC_INVALID];
    assign d_modified = d_excp[EXC_MODIFIED];

endmodule
